// File: Bender.yml
package:
  name: dmc

sources:
  - source/dmc_cfg_pkg.sv
  - source/dfi_pkg.sv
  - source/dmc_app_queue.sv
  - source/dmc_controller.sv
  - source/dmc_phy.sv
  - source/dmc_top.sv
  - target: test
    files:
      - tb/dmc_mem_model.sv
      - tb/tb_dmc.sv

// File: source/dfi_pkg.sv
`default_nettype none

package dfi_pkg;

  typedef logic [12:0] dfi_addr_t;

  // Encoded as {cs_n, ras_n, cas_n, we_n}
  typedef enum logic [3:0] {
    MRS     = 4'b0000,
    REF     = 4'b0001,
    PRE_ALL = 4'b0010,
    ACT     = 4'b0011,
    WR      = 4'b0100,
    RD      = 4'b0101,
    NOP     = 4'b0111
  } sdram_cmd_e;

  typedef struct packed {
    sdram_cmd_e         cmd;
    dmc_cfg_pkg::bank_t bank;
    dfi_addr_t          address;
    logic               cke;
  } dfi_cmd_s;

  typedef enum logic [2:0] {
    WRITE = 3'd0,
    READ  = 3'd1
  } app_cmd_e;

  typedef struct packed {
    app_cmd_e               cmd;
    dmc_cfg_pkg::app_addr_t addr;
  } app_req_s;

endpackage

`default_nettype wire

// File: source/dmc_app_queue.sv
`timescale 1ns/100ps
`default_nettype none

module dmc_app_queue
 #(parameter  dq_data_width_p  = 16
  ,parameter  queue_depth_p    = 4
  ,localparam dq_mask_width_lp = dq_data_width_p >> 3)
  (input  logic                                        ui_clk_i
  ,input  logic                                        reset_i
  ,input  logic                                        app_en_i
  ,input  dfi_pkg::app_cmd_e                           app_cmd_i
  ,input  dmc_cfg_pkg::app_addr_t                      app_addr_i
  ,output logic                                        app_rdy_o
  ,input  logic                                        app_wdf_wren_i
  ,input  logic [dq_data_width_p-1:0]                  app_wdf_data_i
  ,input  logic [dq_mask_width_lp-1:0]                 app_wdf_mask_i
  ,output logic                                        app_wdf_rdy_o
  ,input  logic                                        enable_i
  ,output dfi_pkg::app_req_s                           head_o
  ,output logic                                        head_valid_o
  ,output logic [dq_data_width_p+dq_mask_width_lp-1:0] wd_head_o
  ,output logic                                        wd_valid_o
  ,input  logic                                        pop_i);

  import dfi_pkg::*;

  localparam int req_w_lp   = $bits(app_req_s);
  localparam int wd_w_lp    = dq_data_width_p + dq_mask_width_lp;
  localparam int entry_w_lp = (req_w_lp > wd_w_lp) ? req_w_lp : wd_w_lp;
  localparam int ptr_w_lp   = (queue_depth_p > 1) ? $clog2(queue_depth_p) : 1;
  localparam int cnt_w_lp   = $clog2(queue_depth_p + 1);

  // Lane 0 holds commands, lane 1 holds write words
  logic [1:0] push, pop, full, empty;
  logic [entry_w_lp-1:0] din  [2];
  logic [entry_w_lp-1:0] dout [2];

  function automatic logic [ptr_w_lp-1:0] next_ptr(input logic [ptr_w_lp-1:0] p);
    return (p == ptr_w_lp'(queue_depth_p - 1)) ? '0 : p + 1'b1;
  endfunction

  assign app_rdy_o     = enable_i && !full[0];
  assign app_wdf_rdy_o = !full[1];

  assign push[0] = app_en_i && app_rdy_o;
  assign push[1] = app_wdf_wren_i && app_wdf_rdy_o;
  // A write consumes its data word together with the command
  assign pop[0]  = pop_i;
  assign pop[1]  = pop_i && (head_o.cmd == WRITE);

  assign din[0] = entry_w_lp'({app_cmd_i, app_addr_i});
  assign din[1] = entry_w_lp'({app_wdf_mask_i, app_wdf_data_i});

  assign head_o       = dout[0][req_w_lp-1:0];
  assign head_valid_o = !empty[0];
  assign wd_head_o    = dout[1][wd_w_lp-1:0];
  assign wd_valid_o   = !empty[1];

  for (genvar g = 0; g < 2; g++) begin : lane
    logic [entry_w_lp-1:0] mem_r [queue_depth_p];
    logic [ptr_w_lp-1:0]   wr_ptr_r;
    logic [ptr_w_lp-1:0]   rd_ptr_r;
    logic [cnt_w_lp-1:0]   count_r;

    assign full[g]  = (count_r == cnt_w_lp'(queue_depth_p));
    assign empty[g] = (count_r == '0);
    assign dout[g]  = mem_r[rd_ptr_r];

    always_ff @(posedge ui_clk_i) begin
      if (reset_i) begin
        wr_ptr_r <= '0;
        rd_ptr_r <= '0;
        count_r  <= '0;
      end else begin
        if (push[g])
          wr_ptr_r <= next_ptr(wr_ptr_r);
        if (pop[g])
          rd_ptr_r <= next_ptr(rd_ptr_r);
        count_r <= count_r + cnt_w_lp'(push[g]) - cnt_w_lp'(pop[g]);
      end
    end

    always_ff @(posedge ui_clk_i) begin
      if (push[g])
        mem_r[wr_ptr_r] <= din[g];
    end

    // A write must never land on the unread head entry
    a_no_overflow: assert property (@(posedge ui_clk_i) disable iff (reset_i)
      push[g] |-> (empty[g] || (wr_ptr_r != rd_ptr_r)))
      else $error("queue lane %0d written while full", g);
  end

endmodule

`default_nettype wire

// File: source/dmc_cfg_pkg.sv
`default_nettype none

package dmc_cfg_pkg;

  typedef logic [1:0]  bank_t;
  typedef logic [11:0] row_t;
  typedef logic [7:0]  col_t;

  // Bank, then row, then column from the top bit down
  typedef logic [21:0] app_addr_t;

  // Timing registers, all counted in ui_clk cycles
  typedef struct packed {
    logic [3:0]  trcd;
    logic [3:0]  tcas;
    logic [3:0]  twr_rp;
    logic [3:0]  trfc;
    logic [11:0] trefi;
    logic [7:0]  init_cycles;
  } dmc_timing_s;

endpackage

`default_nettype wire

// File: source/dmc_controller.sv
`timescale 1ns/100ps
`default_nettype none

module dmc_controller
 #(parameter  dq_data_width_p  = 16
  ,localparam dq_mask_width_lp = dq_data_width_p >> 3)
  (input  logic                                        ui_clk_i
  ,input  logic                                        reset_i
  ,input  dmc_cfg_pkg::dmc_timing_s                    dmc_p_i
  ,input  dfi_pkg::app_req_s                           head_i
  ,input  logic                                        head_valid_i
  ,input  logic [dq_data_width_p+dq_mask_width_lp-1:0] wd_head_i
  ,input  logic                                        wd_valid_i
  ,output logic                                        pop_o
  ,input  logic                                        app_ref_req_i
  ,output logic                                        app_ref_ack_o
  ,output dfi_pkg::dfi_cmd_s                           dfi_cmd_o
  ,output logic                                        dfi_wrdata_en_o
  ,output logic [dq_data_width_p-1:0]                  dfi_wrdata_o
  ,output logic [dq_mask_width_lp-1:0]                 dfi_wrdata_mask_o
  ,output logic                                        dfi_rddata_en_o
  ,output logic                                        init_calib_complete_o);

  import dmc_cfg_pkg::*;
  import dfi_pkg::*;

  typedef enum logic [3:0] {
    INIT_WAIT,
    INIT_PRE,
    INIT_MRS,
    INIT_REF,
    IDLE,
    ACTIVATE,
    ACCESS,
    RECOVER,
    REFRESH
  } state_e;

  state_e      state_r, state_n;
  logic [7:0]  wait_r, wait_n;
  logic        wait_done;
  logic [1:0]  ref_cnt_r;
  logic        init_done_r;
  logic [11:0] refi_cnt_r;
  logic        refi_hit;
  logic        ref_pend_r;
  logic        app_ref_done_r;
  logic        app_ref_ack_r;
  logic        app_ref_take;
  logic        ref_issue;
  logic        access_ok;
  logic [15:0] rd_pipe_r;
  logic [3:0]  act_age_r;
  bank_t       bank;
  row_t        row;
  col_t        col;

  assign {bank, row, col} = head_i.addr;
  assign {dfi_wrdata_mask_o, dfi_wrdata_o} = wd_head_i;

  assign wait_done    = (wait_r <= 8'd1);
  assign refi_hit     = init_done_r && (refi_cnt_r >= dmc_p_i.trefi - 12'd1);
  // An app request is served once per rising level
  assign app_ref_take = app_ref_req_i && !app_ref_done_r;
  assign access_ok    = head_valid_i && ((head_i.cmd == READ) || wd_valid_i);

  // Each read enable lands tcas cycles after the RD reaches the pins
  assign dfi_rddata_en_o       = rd_pipe_r[dmc_p_i.tcas];
  assign app_ref_ack_o         = app_ref_ack_r;
  assign init_calib_complete_o = init_done_r;

  always_comb begin
    state_n           = state_r;
    wait_n            = (wait_r != '0) ? wait_r - 8'd1 : wait_r;
    dfi_cmd_o.cmd     = NOP;
    dfi_cmd_o.bank    = bank;
    dfi_cmd_o.address = '0;
    dfi_cmd_o.cke     = (state_r != INIT_WAIT);
    dfi_wrdata_en_o   = 1'b0;
    pop_o             = 1'b0;
    ref_issue         = 1'b0;
    case (state_r)
      INIT_WAIT: if (wait_done) begin
        wait_n  = 8'd2;
        state_n = INIT_PRE;
      end
      INIT_PRE: if (wait_done) begin
        dfi_cmd_o.cmd     = PRE_ALL;
        dfi_cmd_o.address = 13'h400;
        wait_n            = 8'(dmc_p_i.twr_rp);
        state_n           = INIT_MRS;
      end
      INIT_MRS: if (wait_done) begin
        // Burst length one, CAS latency in A6..A4
        dfi_cmd_o.cmd     = MRS;
        dfi_cmd_o.address = {6'b0, dmc_p_i.tcas[2:0], 4'b0000};
        wait_n            = 8'd2;
        state_n           = INIT_REF;
      end
      INIT_REF: if (wait_done) begin
        if (ref_cnt_r < 2'd2) begin
          dfi_cmd_o.cmd = REF;
          wait_n        = 8'(dmc_p_i.trfc);
        end else begin
          state_n = IDLE;
        end
      end
      IDLE: begin
        if (ref_pend_r || app_ref_take) begin
          dfi_cmd_o.cmd = REF;
          ref_issue     = 1'b1;
          wait_n        = 8'(dmc_p_i.trfc);
          state_n       = REFRESH;
        end else if (access_ok) begin
          dfi_cmd_o.cmd     = ACT;
          dfi_cmd_o.address = {1'b0, row};
          wait_n            = 8'(dmc_p_i.trcd) - 8'd1;
          state_n           = ACTIVATE;
        end
      end
      ACTIVATE: if (wait_done) begin
        state_n = ACCESS;
      end
      ACCESS: begin
        // A10 set for auto-precharge
        dfi_cmd_o.address = {2'b00, 1'b1, 2'b00, col};
        if (head_i.cmd == READ) begin
          dfi_cmd_o.cmd = RD;
        end else begin
          dfi_cmd_o.cmd   = WR;
          dfi_wrdata_en_o = 1'b1;
        end
        pop_o   = 1'b1;
        wait_n  = 8'(dmc_p_i.twr_rp);
        state_n = RECOVER;
      end
      RECOVER, REFRESH: if (wait_done) begin
        state_n = IDLE;
      end
      default: state_n = INIT_WAIT;
    endcase
  end

  always_ff @(posedge ui_clk_i) begin
    if (reset_i) begin
      state_r        <= INIT_WAIT;
      wait_r         <= dmc_p_i.init_cycles;
      ref_cnt_r      <= '0;
      init_done_r    <= 1'b0;
      refi_cnt_r     <= '0;
      ref_pend_r     <= 1'b0;
      app_ref_done_r <= 1'b0;
      app_ref_ack_r  <= 1'b0;
      rd_pipe_r      <= '0;
      act_age_r      <= '0;
    end else begin
      state_r <= state_n;
      wait_r  <= wait_n;
      if (state_r == INIT_REF && wait_done && ref_cnt_r < 2'd2)
        ref_cnt_r <= ref_cnt_r + 2'd1;
      if (state_r == INIT_REF && state_n == IDLE)
        init_done_r <= 1'b1;
      if (init_done_r)
        refi_cnt_r <= refi_hit ? '0 : refi_cnt_r + 12'd1;
      if (refi_hit)
        ref_pend_r <= 1'b1;
      else if (ref_issue)
        ref_pend_r <= 1'b0;
      if (!app_ref_req_i)
        app_ref_done_r <= 1'b0;
      else if (ref_issue)
        app_ref_done_r <= 1'b1;
      app_ref_ack_r <= ref_issue && app_ref_take;
      rd_pipe_r     <= {rd_pipe_r[14:0], dfi_cmd_o.cmd == RD};
      if (dfi_cmd_o.cmd == ACT)
        act_age_r <= 4'd1;
      else if (act_age_r != 4'hf)
        act_age_r <= act_age_r + 4'd1;
    end
  end

  a_no_access_before_init: assert property (@(posedge ui_clk_i) disable iff (reset_i)
    !init_done_r |-> !(dfi_cmd_o.cmd inside {ACT, RD, WR}))
    else $error("access command issued before init complete");

  a_trcd: assert property (@(posedge ui_clk_i) disable iff (reset_i)
    (dfi_cmd_o.cmd inside {RD, WR}) |-> (act_age_r >= dmc_p_i.trcd))
    else $error("RD or WR issued inside trcd of ACT");

endmodule

`default_nettype wire

// File: source/dmc_phy.sv
`timescale 1ns/100ps
`default_nettype none

module dmc_phy
 #(parameter  dq_data_width_p  = 16
  ,localparam dq_mask_width_lp = dq_data_width_p >> 3)
  (input  logic                        ui_clk_i
  ,input  logic                        reset_i
  ,input  dfi_pkg::dfi_cmd_s           dfi_cmd_i
  ,input  logic                        dfi_wrdata_en_i
  ,input  logic [dq_data_width_p-1:0]  dfi_wrdata_i
  ,input  logic [dq_mask_width_lp-1:0] dfi_wrdata_mask_i
  ,input  logic                        dfi_rddata_en_i
  ,output logic [dq_data_width_p-1:0]  dfi_rddata_o
  ,output logic                        dfi_rddata_valid_o
  ,output logic                        ddr_cke_o
  ,output logic                        ddr_cs_n_o
  ,output logic                        ddr_ras_n_o
  ,output logic                        ddr_cas_n_o
  ,output logic                        ddr_we_n_o
  ,output dmc_cfg_pkg::bank_t          ddr_ba_o
  ,output dfi_pkg::dfi_addr_t          ddr_addr_o
  ,output logic [dq_data_width_p-1:0]  ddr_dq_oen_o
  ,output logic [dq_data_width_p-1:0]  ddr_dq_o
  ,output logic [dq_mask_width_lp-1:0] ddr_dm_o
  ,input  logic [dq_data_width_p-1:0]  ddr_dq_i);

  import dfi_pkg::*;

  logic cs_n, ras_n, cas_n, we_n;

  // Command encoding is the strobe pattern itself
  assign {cs_n, ras_n, cas_n, we_n} = dfi_cmd_i.cmd;

  always_ff @(posedge ui_clk_i) begin
    if (reset_i) begin
      ddr_cke_o <= 1'b0;
      {ddr_cs_n_o, ddr_ras_n_o, ddr_cas_n_o, ddr_we_n_o} <= NOP;
      ddr_dq_oen_o       <= '1;
      dfi_rddata_valid_o <= 1'b0;
    end else begin
      ddr_cke_o   <= dfi_cmd_i.cke;
      ddr_cs_n_o  <= cs_n;
      ddr_ras_n_o <= ras_n;
      ddr_cas_n_o <= cas_n;
      ddr_we_n_o  <= we_n;
      // Drive dq only in the cycle the WR sits on the pins
      ddr_dq_oen_o       <= {dq_data_width_p{!dfi_wrdata_en_i}};
      dfi_rddata_valid_o <= dfi_rddata_en_i;
    end
  end

  always_ff @(posedge ui_clk_i) begin
    ddr_ba_o   <= dfi_cmd_i.bank;
    ddr_addr_o <= dfi_cmd_i.address;
    if (dfi_wrdata_en_i) begin
      ddr_dq_o <= dfi_wrdata_i;
      ddr_dm_o <= dfi_wrdata_mask_i;
    end
    if (dfi_rddata_en_i)
      dfi_rddata_o <= ddr_dq_i;
  end

endmodule

`default_nettype wire

// File: source/dmc_top.sv
`timescale 1ns/100ps
`default_nettype none

module dmc_top
 #(parameter  dq_data_width_p  = 16
  ,parameter  queue_depth_p    = 4
  ,localparam dq_mask_width_lp = dq_data_width_p >> 3)
  (input  logic                        ui_clk_i
  ,input  logic                        reset_i
  ,input  dmc_cfg_pkg::dmc_timing_s    dmc_p_i
  // User interface
  ,input  dmc_cfg_pkg::app_addr_t      app_addr_i
  ,input  dfi_pkg::app_cmd_e           app_cmd_i
  ,input  logic                        app_en_i
  ,output logic                        app_rdy_o
  ,input  logic                        app_wdf_wren_i
  ,input  logic [dq_data_width_p-1:0]  app_wdf_data_i
  ,input  logic [dq_mask_width_lp-1:0] app_wdf_mask_i
  ,input  logic                        app_wdf_end_i
  ,output logic                        app_wdf_rdy_o
  ,output logic                        app_rd_data_valid_o
  ,output logic [dq_data_width_p-1:0]  app_rd_data_o
  ,output logic                        app_rd_data_end_o
  ,input  logic                        app_ref_req_i
  ,output logic                        app_ref_ack_o
  ,output logic                        init_calib_complete_o
  // SDRAM pins
  ,output logic                        ddr_cke_o
  ,output logic                        ddr_cs_n_o
  ,output logic                        ddr_ras_n_o
  ,output logic                        ddr_cas_n_o
  ,output logic                        ddr_we_n_o
  ,output dmc_cfg_pkg::bank_t          ddr_ba_o
  ,output dfi_pkg::dfi_addr_t          ddr_addr_o
  ,output logic [dq_data_width_p-1:0]  ddr_dq_oen_o
  ,output logic [dq_data_width_p-1:0]  ddr_dq_o
  ,output logic [dq_mask_width_lp-1:0] ddr_dm_o
  ,input  logic [dq_data_width_p-1:0]  ddr_dq_i);

  import dfi_pkg::*;

  app_req_s                                  head;
  logic                                      head_valid;
  logic [dq_data_width_p+dq_mask_width_lp-1:0] wd_head;
  logic                                      wd_valid;
  logic                                      pop;
  dfi_cmd_s                                  dfi_cmd;
  logic                                      dfi_wrdata_en;
  logic [dq_data_width_p-1:0]                dfi_wrdata;
  logic [dq_mask_width_lp-1:0]               dfi_wrdata_mask;
  logic                                      dfi_rddata_en;

  // Single-word transfers, so every valid word is also the last
  assign app_rd_data_end_o = app_rd_data_valid_o;

  dmc_app_queue #
    (.dq_data_width_p ( dq_data_width_p )
    ,.queue_depth_p   ( queue_depth_p   ))
  dmc_app_queue_i
    (.ui_clk_i       ( ui_clk_i              )
    ,.reset_i        ( reset_i               )
    ,.app_en_i       ( app_en_i              )
    ,.app_cmd_i      ( app_cmd_i             )
    ,.app_addr_i     ( app_addr_i            )
    ,.app_rdy_o      ( app_rdy_o             )
    ,.app_wdf_wren_i ( app_wdf_wren_i        )
    ,.app_wdf_data_i ( app_wdf_data_i        )
    ,.app_wdf_mask_i ( app_wdf_mask_i        )
    ,.app_wdf_rdy_o  ( app_wdf_rdy_o         )
    ,.enable_i       ( init_calib_complete_o )
    ,.head_o         ( head                  )
    ,.head_valid_o   ( head_valid            )
    ,.wd_head_o      ( wd_head               )
    ,.wd_valid_o     ( wd_valid              )
    ,.pop_i          ( pop                   ));

  dmc_controller #(.dq_data_width_p(dq_data_width_p)) dmc_controller_i
    (.ui_clk_i              ( ui_clk_i              )
    ,.reset_i               ( reset_i               )
    ,.dmc_p_i               ( dmc_p_i               )
    ,.head_i                ( head                  )
    ,.head_valid_i          ( head_valid            )
    ,.wd_head_i             ( wd_head               )
    ,.wd_valid_i            ( wd_valid              )
    ,.pop_o                 ( pop                   )
    ,.app_ref_req_i         ( app_ref_req_i         )
    ,.app_ref_ack_o         ( app_ref_ack_o         )
    ,.dfi_cmd_o             ( dfi_cmd               )
    ,.dfi_wrdata_en_o       ( dfi_wrdata_en         )
    ,.dfi_wrdata_o          ( dfi_wrdata            )
    ,.dfi_wrdata_mask_o     ( dfi_wrdata_mask       )
    ,.dfi_rddata_en_o       ( dfi_rddata_en         )
    ,.init_calib_complete_o ( init_calib_complete_o ));

  dmc_phy #(.dq_data_width_p(dq_data_width_p)) dmc_phy_i
    (.ui_clk_i           ( ui_clk_i            )
    ,.reset_i            ( reset_i             )
    ,.dfi_cmd_i          ( dfi_cmd             )
    ,.dfi_wrdata_en_i    ( dfi_wrdata_en       )
    ,.dfi_wrdata_i       ( dfi_wrdata          )
    ,.dfi_wrdata_mask_i  ( dfi_wrdata_mask     )
    ,.dfi_rddata_en_i    ( dfi_rddata_en       )
    ,.dfi_rddata_o       ( app_rd_data_o       )
    ,.dfi_rddata_valid_o ( app_rd_data_valid_o )
    ,.ddr_cke_o          ( ddr_cke_o           )
    ,.ddr_cs_n_o         ( ddr_cs_n_o          )
    ,.ddr_ras_n_o        ( ddr_ras_n_o         )
    ,.ddr_cas_n_o        ( ddr_cas_n_o         )
    ,.ddr_we_n_o         ( ddr_we_n_o          )
    ,.ddr_ba_o           ( ddr_ba_o            )
    ,.ddr_addr_o         ( ddr_addr_o          )
    ,.ddr_dq_oen_o       ( ddr_dq_oen_o        )
    ,.ddr_dq_o           ( ddr_dq_o            )
    ,.ddr_dm_o           ( ddr_dm_o            )
    ,.ddr_dq_i           ( ddr_dq_i            ));

endmodule

`default_nettype wire

// File: tb/dmc_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module dmc_mem_model
 #(parameter  dq_data_width_p  = 16
  ,localparam dq_mask_width_lp = dq_data_width_p >> 3)
  (input  logic                        ui_clk_i
  ,input  logic                        reset_i
  ,input  dmc_cfg_pkg::dmc_timing_s    dmc_p_i
  ,input  logic                        ddr_cke_i
  ,input  logic                        ddr_cs_n_i
  ,input  logic                        ddr_ras_n_i
  ,input  logic                        ddr_cas_n_i
  ,input  logic                        ddr_we_n_i
  ,input  dmc_cfg_pkg::bank_t          ddr_ba_i
  ,input  dfi_pkg::dfi_addr_t          ddr_addr_i
  ,input  logic [dq_data_width_p-1:0]  ddr_dq_oen_i
  ,input  logic [dq_data_width_p-1:0]  ddr_dq_i
  ,input  logic [dq_mask_width_lp-1:0] ddr_dm_i
  ,output logic [dq_data_width_p-1:0]  ddr_dq_o
  ,output logic                        timing_err_o
  ,output int                          ref_count_o);

  import dmc_cfg_pkg::*;
  import dfi_pkg::*;

  sdram_cmd_e                 cmd;
  logic [dq_data_width_p-1:0] mem [app_addr_t];
  logic [dq_data_width_p-1:0] word;
  logic [dq_data_width_p-1:0] pend_d [16];
  row_t                       open_row [4];
  int                         act_cyc [4];
  logic [3:0]                 open_r;
  logic                       mrs_seen;
  int                         cyc;
  int                         ref_cyc;
  app_addr_t                  key;

  assign cmd      = sdram_cmd_e'({ddr_cs_n_i, ddr_ras_n_i, ddr_cas_n_i, ddr_we_n_i});
  // Data for a RD shows up tcas cycles after the RD on the pins
  assign ddr_dq_o = pend_d[dmc_p_i.tcas - 4'd1];

  task automatic flag(input string what);
    $display("%0t memory model: %s", $time, what);
    timing_err_o = 1'b1;
  endtask

  always @(posedge ui_clk_i) begin
    for (int i = 15; i > 0; i--)
      pend_d[i] <= pend_d[i-1];
    pend_d[0] <= 'x;
    if (reset_i) begin
      timing_err_o = 1'b0;
      ref_count_o  = 0;
      open_r       = '0;
      mrs_seen     = 1'b0;
      cyc          = 0;
      ref_cyc      = -100;
    end else begin
      cyc++;
      if (cmd != NOP && !ddr_cke_i)
        flag("command issued with cke low");
      if (cmd inside {MRS, ACT, RD, WR, REF} && cyc - ref_cyc < dmc_p_i.trfc)
        flag("command inside trfc of REF");
      case (cmd)
        MRS: begin
          if (ddr_addr_i[6:4] != dmc_p_i.tcas[2:0])
            flag("MRS carries the wrong CAS latency");
          mrs_seen = 1'b1;
        end
        ACT: begin
          if (!mrs_seen)
            flag("ACT before MRS");
          if (open_r[ddr_ba_i])
            flag("ACT to a bank that is already open");
          open_row[ddr_ba_i] = ddr_addr_i[11:0];
          open_r[ddr_ba_i]   = 1'b1;
          act_cyc[ddr_ba_i]  = cyc;
        end
        RD, WR: begin
          if (!open_r[ddr_ba_i])
            flag("access to a closed bank");
          if (cyc - act_cyc[ddr_ba_i] < dmc_p_i.trcd)
            flag("RD or WR inside trcd of ACT");
          if (!ddr_addr_i[10])
            flag("access without auto-precharge");
          key  = {ddr_ba_i, open_row[ddr_ba_i], ddr_addr_i[7:0]};
          word = mem.exists(key) ? mem[key] : '0;
          if (cmd == WR) begin
            if (ddr_dq_oen_i != '0)
              flag("WR without dq driven");
            for (int b = 0; b < dq_mask_width_lp; b++)
              if (!ddr_dm_i[b])
                word[8*b +: 8] = ddr_dq_i[8*b +: 8];
            mem[key] = word;
          end else begin
            pend_d[0] <= word;
          end
          open_r[ddr_ba_i] = 1'b0;
        end
        REF: begin
          if (open_r != '0)
            flag("REF while an access is in progress");
          ref_count_o++;
          ref_cyc = cyc;
        end
        PRE_ALL: open_r = '0;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: tb/tb_dmc.sv
`timescale 1ns/100ps
`default_nettype none

module tb_dmc;

  import dmc_cfg_pkg::*;
  import dfi_pkg::*;

  localparam int dw_lp = 16;
  localparam int mw_lp = dw_lp >> 3;

  typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_REF, OP_IDLE} op_e;

  typedef struct packed {
    op_e              op;
    app_addr_t        addr;
    logic [dw_lp-1:0] data;
    logic [mw_lp-1:0] mask;
    logic             wait_rd;
  } step_s;

  logic clk = 1'b0;
  logic reset;
  dmc_timing_s timing;
  app_addr_t app_addr;
  app_cmd_e app_cmd;
  logic app_en, app_rdy, app_wdf_wren, app_wdf_rdy;
  logic [dw_lp-1:0] app_wdf_data, app_rd_data;
  logic [mw_lp-1:0] app_wdf_mask;
  logic app_rd_valid, app_rd_end, app_ref_req, app_ref_ack, init_done;
  logic ddr_cke, ddr_cs_n, ddr_ras_n, ddr_cas_n, ddr_we_n;
  bank_t ddr_ba;
  dfi_addr_t ddr_addr;
  logic [dw_lp-1:0] ddr_dq_oen, ddr_dq_out, ddr_dq_in;
  logic [mw_lp-1:0] ddr_dm;
  logic model_err;
  int ref_count;

  step_s steps[$];
  logic [dw_lp-1:0] ref_mem [app_addr_t];
  logic [dw_lp-1:0] exp_q[$];
  logic [dw_lp-1:0] exp_word;
  int ack_count = 0;
  logic full_seen = 1'b0;
  logic wdf_full_seen = 1'b0;

  always #5 clk = ~clk;

  dmc_top #(.dq_data_width_p(dw_lp), .queue_depth_p(4)) dmc_top_i
    (.ui_clk_i(clk), .reset_i(reset), .dmc_p_i(timing)
    ,.app_addr_i(app_addr), .app_cmd_i(app_cmd), .app_en_i(app_en), .app_rdy_o(app_rdy)
    ,.app_wdf_wren_i(app_wdf_wren), .app_wdf_data_i(app_wdf_data)
    ,.app_wdf_mask_i(app_wdf_mask), .app_wdf_end_i(app_wdf_wren), .app_wdf_rdy_o(app_wdf_rdy)
    ,.app_rd_data_valid_o(app_rd_valid), .app_rd_data_o(app_rd_data)
    ,.app_rd_data_end_o(app_rd_end), .app_ref_req_i(app_ref_req)
    ,.app_ref_ack_o(app_ref_ack), .init_calib_complete_o(init_done)
    ,.ddr_cke_o(ddr_cke), .ddr_cs_n_o(ddr_cs_n), .ddr_ras_n_o(ddr_ras_n)
    ,.ddr_cas_n_o(ddr_cas_n), .ddr_we_n_o(ddr_we_n), .ddr_ba_o(ddr_ba)
    ,.ddr_addr_o(ddr_addr), .ddr_dq_oen_o(ddr_dq_oen), .ddr_dq_o(ddr_dq_out)
    ,.ddr_dm_o(ddr_dm), .ddr_dq_i(ddr_dq_in));

  dmc_mem_model #(.dq_data_width_p(dw_lp)) mem_model_i
    (.ui_clk_i(clk), .reset_i(reset), .dmc_p_i(timing)
    ,.ddr_cke_i(ddr_cke), .ddr_cs_n_i(ddr_cs_n), .ddr_ras_n_i(ddr_ras_n)
    ,.ddr_cas_n_i(ddr_cas_n), .ddr_we_n_i(ddr_we_n), .ddr_ba_i(ddr_ba)
    ,.ddr_addr_i(ddr_addr), .ddr_dq_oen_i(ddr_dq_oen), .ddr_dq_i(ddr_dq_out)
    ,.ddr_dm_i(ddr_dm), .ddr_dq_o(ddr_dq_in), .timing_err_o(model_err)
    ,.ref_count_o(ref_count));

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1);
  endtask

  function automatic app_addr_t rand_addr();
    return {bank_t'($urandom), row_t'($urandom), col_t'($urandom)};
  endfunction

  // A masked write blocks exactly one byte lane
  task automatic add_step(input op_e op, input app_addr_t addr, input logic masked,
                          input logic wait_rd);
    step_s s;
    s.op      = op;
    s.addr    = addr;
    s.data    = dw_lp'($urandom);
    s.mask    = masked ? mw_lp'(1) << $urandom_range(mw_lp - 1) : '0;
    s.wait_rd = wait_rd;
    steps.push_back(s);
  endtask

  // Drives one command, plus its data word for a write, until both are taken
  task automatic send_cmd(input step_s s);
    logic cmd_pend, wd_pend, cmd_go, wd_go;
    int n;
    cmd_pend = 1'b1;
    wd_pend  = (s.op == OP_WRITE);
    n        = 0;
    if (s.op == OP_WRITE) begin
      for (int b = 0; b < mw_lp; b++)
        if (!s.mask[b]) begin
          exp_word = ref_mem.exists(s.addr) ? ref_mem[s.addr] : '0;
          exp_word[8*b +: 8] = s.data[8*b +: 8];
          ref_mem[s.addr] = exp_word;
        end
    end else begin
      exp_q.push_back(ref_mem.exists(s.addr) ? ref_mem[s.addr] : '0);
    end
    app_en       = 1'b1;
    app_cmd      = (s.op == OP_WRITE) ? WRITE : READ;
    app_addr     = s.addr;
    app_wdf_wren = wd_pend;
    app_wdf_data = s.data;
    app_wdf_mask = s.mask;
    while (cmd_pend || wd_pend) begin
      cmd_go = cmd_pend && app_rdy;
      wd_go  = wd_pend && app_wdf_rdy;
      @(negedge clk);
      if (cmd_go) begin
        app_en   = 1'b0;
        cmd_pend = 1'b0;
      end
      if (wd_go) begin
        app_wdf_wren = 1'b0;
        wd_pend      = 1'b0;
      end
      n++;
      assert (n < 200) else fail_now("timeout waiting for the app port to take a command");
    end
  endtask

  task automatic drain_reads();
    int n;
    n = 0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
      n++;
      assert (n < 300) else fail_now("timeout waiting for read data to return");
    end
  endtask

  task automatic request_refresh();
    int acks_before, refs_before, n;
    acks_before = ack_count;
    refs_before = ref_count;
    n           = 0;
    app_ref_req = 1'b1;
    while (ack_count == acks_before) begin
      @(negedge clk);
      n++;
      assert (n < 200) else fail_now("timeout waiting for app_ref_ack_o");
    end
    app_ref_req = 1'b0;
    repeat (20) @(negedge clk);
    assert (ack_count == acks_before + 1)
      else fail_now($sformatf("MISMATCH time=%0t app_ref_ack_o pulses expected=%0d got=%0d",
                              $time, 1, ack_count - acks_before));
    assert (ref_count > refs_before) else fail_now("no REF reached the memory for the request");
  endtask

  // Read return, refresh ack and model error monitor
  always @(negedge clk) begin
    if (!reset) begin
      assert (!model_err) else fail_now("memory model reported a command timing error");
      if (!init_done)
        assert (!app_rdy) else fail_now("app_rdy_o high before init completed");
      if (init_done && !app_rdy)
        full_seen = 1'b1;
      if (!app_wdf_rdy)
        wdf_full_seen = 1'b1;
      if (app_ref_ack)
        ack_count++;
      if (app_rd_valid) begin
        assert (exp_q.size() > 0) else fail_now("read data returned with no read outstanding");
        exp_word = exp_q.pop_front();
        assert (app_rd_data == exp_word)
          else fail_now($sformatf("MISMATCH time=%0t app_rd_data_o expected=%h got=%h",
                                  $time, exp_word, app_rd_data));
        assert (app_rd_end)
          else fail_now($sformatf("MISMATCH time=%0t app_rd_data_end_o expected=1 got=%b",
                                  $time, app_rd_end));
      end
    end
  end

  initial begin
    app_addr_t a0, b[4], r;
    int n;
    void'($urandom(32'hfded_13a2));
    timing       = '{trcd: 4'd3, tcas: 4'd2, twr_rp: 4'd3, trfc: 4'd4,
                     trefi: 12'd120, init_cycles: 8'd20};
    reset        = 1'b1;
    app_en       = 1'b0;
    app_cmd      = WRITE;
    app_addr     = '0;
    app_wdf_wren = 1'b0;
    app_wdf_data = '0;
    app_wdf_mask = '0;
    app_ref_req  = 1'b0;

    a0 = rand_addr();
    add_step(OP_WRITE, a0, 1'b0, 1'b0);
    add_step(OP_READ, a0, 1'b0, 1'b1);
    add_step(OP_WRITE, a0, 1'b1, 1'b0);
    add_step(OP_READ, a0, 1'b0, 1'b1);
    // One address per bank, then reads back to back
    for (int i = 0; i < 4; i++) begin
      b[i] = {bank_t'(i), row_t'($urandom), col_t'($urandom)};
      add_step(OP_WRITE, b[i], 1'b0, 1'b0);
    end
    for (int i = 0; i < 4; i++)
      add_step(OP_READ, b[i], 1'b0, i == 3);
    add_step(OP_REF, '0, 1'b0, 1'b0);
    add_step(OP_READ, a0, 1'b0, 1'b0);
    add_step(OP_READ, b[2], 1'b0, 1'b1);
    add_step(OP_IDLE, '0, 1'b0, 1'b0);
    for (int i = 0; i < 12; i++) begin
      r = rand_addr();
      add_step(OP_WRITE, r, i[0], 1'b0);
      add_step(OP_READ, r, 1'b0, 1'b0);
    end
    add_step(OP_READ, b[0], 1'b0, 1'b1);

    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    n = 0;
    while (!init_done) begin
      @(negedge clk);
      n++;
      assert (n < 500) else fail_now("timeout waiting for init_calib_complete_o");
    end

    foreach (steps[i]) begin
      case (steps[i].op)
        OP_WRITE, OP_READ: send_cmd(steps[i]);
        OP_REF:            request_refresh();
        default:           repeat (130) @(negedge clk);
      endcase
      if (steps[i].wait_rd)
        drain_reads();
    end

    assert (full_seen) else fail_now("app_rdy_o never dropped while the queue was full");
    assert (wdf_full_seen)
      else fail_now("app_wdf_rdy_o never dropped while the data FIFO was full");
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
source/dmc_cfg_pkg.sv
source/dfi_pkg.sv
source/dmc_app_queue.sv
source/dmc_controller.sv
source/dmc_phy.sv
source/dmc_top.sv
tb/dmc_mem_model.sv
tb/tb_dmc.sv
